/* hw/tcdm_pkg.sv */
// **********************************************************
// tcdm wide router package
// shared widths, typedefs and request structs for the wide
// initiator port, the lane slices and the scratchpad banks
// **********************************************************

package tcdm_pkg;

  // scratchpad geometry
  localparam int unsigned NB_BANKS = 8;
  localparam int unsigned NB_LANES = 4;
  localparam int unsigned ROW_AW   = 6;

  // derived widths
  localparam int unsigned WORD_W   = 32;
  localparam int unsigned WIDE_W   = WORD_W * NB_LANES;
  localparam int unsigned OFFSET_W = $clog2(NB_BANKS);
  // first byte address bit above the bank offset
  localparam int unsigned ROW_LSB  = OFFSET_W + 2;

  typedef logic [31:0]           wide_addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [WIDE_W-1:0]     wide_data_t;
  typedef logic [WIDE_W/8-1:0]   wide_be_t;
  typedef logic [OFFSET_W-1:0]   bank_idx_t;
  typedef logic [ROW_AW-1:0]     row_addr_t;
  typedef logic [NB_BANKS-1:0]   bank_mask_t;

  // wide request as seen at the initiator port
  // wen high means read
  typedef struct packed {
    logic       wen;
    wide_be_t   be;
    wide_addr_t addr;
    wide_data_t data;
  } wide_req_t;

  // one 32-bit lane, already in bank row terms
  typedef struct packed {
    logic      req;
    logic      wen;
    logic [3:0] be;
    row_addr_t row;
    word_t     data;
  } lane_req_t;

endpackage

/* hw/wide_req_fifo.sv */
// **********************************************************
// wide request FIFO
// optional circular buffer in front of the router, or a
// plain pass-through when the depth is zero
// **********************************************************

`timescale 1ns/1ns

module wide_req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  tcdm_pkg::wide_req_t wreq_i,
  output logic                gnt_o,
  input  logic                pop_i,
  output logic                valid_o,
  output tcdm_pkg::wide_req_t head_o
);

  generate
    if (FIFO_DEPTH == 0) begin : gen_bypass
      // request goes straight to the router
      assign valid_o = req_i;
      assign head_o  = wreq_i;
      // grant only when the router actually issues
      assign gnt_o   = pop_i;
    end else begin : gen_fifo
      localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
      localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

      tcdm_pkg::wide_req_t mem_q [FIFO_DEPTH];
      logic [PTR_W-1:0]    wr_ptr_q;
      logic [PTR_W-1:0]    rd_ptr_q;
      logic [CNT_W-1:0]    count_q;
      logic                push;
      logic                pop;

      // not full means we can take one more
      assign gnt_o   = (count_q != CNT_W'(FIFO_DEPTH));
      assign valid_o = (count_q != '0);
      assign push    = req_i & gnt_o;
      assign pop     = pop_i & valid_o;
      assign head_o  = mem_q[rd_ptr_q];

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          wr_ptr_q <= '0;
          rd_ptr_q <= '0;
          count_q  <= '0;
        end else begin
          // pointers wrap by compare, depth need not be a power of two
          if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
          end
          if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
          end
          case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
          endcase
        end
      end

      // storage
      always_ff @(posedge clk_i) begin
        if (push) begin
          mem_q[wr_ptr_q] <= wreq_i;
        end
      end
    end
  endgenerate

endmodule

/* hw/shallow_router.sv */
// **********************************************************
// shallow router
// splits the wide head request into 32-bit lanes with bank
// row addresses and rebuilds the wide read response
// **********************************************************

`timescale 1ns/1ns

module shallow_router (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // FIFO head
  input  logic                                            valid_i,
  input  tcdm_pkg::wide_req_t                             head_i,
  output logic                                            pop_o,
  // lanes towards the reorder stage
  output tcdm_pkg::lane_req_t [tcdm_pkg::NB_LANES-1:0]    lanes_o,
  output tcdm_pkg::bank_idx_t                             offset_o,
  input  logic                                            lane_gnt_i,
  input  tcdm_pkg::word_t [tcdm_pkg::NB_LANES-1:0]        lane_rdata_i,
  // wide response
  output logic                                            r_valid_o,
  output tcdm_pkg::wide_data_t                            r_data_o
);

  // lane position is one bit wider than the offset to catch the wrap
  localparam int unsigned POS_W = tcdm_pkg::OFFSET_W + 1;

  tcdm_pkg::row_addr_t head_row;
  logic                issue;
  logic                rd_issued_q;

  // word interleaving
  // bits 1:0 byte in word, then bank offset, then row
  assign offset_o = head_i.addr[tcdm_pkg::ROW_LSB-1:2];
  assign head_row = head_i.addr[tcdm_pkg::ROW_LSB +: tcdm_pkg::ROW_AW];

  // all four banks free and a head waiting
  assign issue = valid_i & lane_gnt_i;
  assign pop_o = issue;

  generate
    for (genvar k = 0; k < tcdm_pkg::NB_LANES; k++) begin : gen_lane
      logic [POS_W-1:0] lane_pos;

      // bank position before the modulo
      assign lane_pos = {1'b0, offset_o} + POS_W'(k);

      // req is the head valid, the reorder stage qualifies it with the grant
      assign lanes_o[k].req  = valid_i;
      assign lanes_o[k].wen  = head_i.wen;
      assign lanes_o[k].be   = head_i.be[k*4 +: 4];
      assign lanes_o[k].data = head_i.data[k*tcdm_pkg::WORD_W +: tcdm_pkg::WORD_W];

      // lanes that wrap past the last bank land on the next row
      assign lanes_o[k].row  = head_row + tcdm_pkg::row_addr_t'(lane_pos[POS_W-1]);

      // response word for this lane, already back in lane order
      assign r_data_o[k*tcdm_pkg::WORD_W +: tcdm_pkg::WORD_W] = lane_rdata_i[k];
    end
  endgenerate

  // banks answer one cycle after the read was issued
  // writes never produce a response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_issued_q <= 1'b0;
    end else begin
      rd_issued_q <= issue & head_i.wen;
    end
  end

  assign r_valid_o = rd_issued_q;

endmodule

/* hw/lane_reorder.sv */
// **********************************************************
// lane to bank reorder
// rotates lanes onto banks, grants when no target is busy
// and rotates the read data back into lane order
// **********************************************************

`timescale 1ns/1ns

module lane_reorder (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  tcdm_pkg::bank_idx_t                           offset_i,
  input  tcdm_pkg::lane_req_t [tcdm_pkg::NB_LANES-1:0]  lanes_i,
  input  tcdm_pkg::bank_mask_t                          bank_busy_i,
  output logic                                          lane_gnt_o,
  output tcdm_pkg::word_t [tcdm_pkg::NB_LANES-1:0]      lane_rdata_o,
  output tcdm_pkg::lane_req_t [tcdm_pkg::NB_BANKS-1:0]  bank_req_o,
  input  tcdm_pkg::word_t [tcdm_pkg::NB_BANKS-1:0]      bank_rdata_i
);

  tcdm_pkg::lane_req_t [tcdm_pkg::NB_BANKS-1:0] rot_req;
  tcdm_pkg::bank_mask_t                         tgt_mask;
  tcdm_pkg::bank_idx_t                          bank_sel;
  tcdm_pkg::bank_idx_t                          rd_offset_q;
  logic                                         issue_rd;

  // lane k sits on bank (offset + k) mod NB_BANKS
  always_comb begin
    rot_req  = '0;
    tgt_mask = '0;
    bank_sel = '0;
    for (int k = 0; k < tcdm_pkg::NB_LANES; k++) begin
      // truncation to the bank index width does the modulo
      bank_sel           = tcdm_pkg::bank_idx_t'(offset_i + k);
      rot_req[bank_sel]  = lanes_i[k];
      tgt_mask[bank_sel] = lanes_i[k].req;
    end
  end

  // no arbitration, go only if every targeted bank is free
  assign lane_gnt_o = ~|(tgt_mask & bank_busy_i);

  generate
    for (genvar b = 0; b < tcdm_pkg::NB_BANKS; b++) begin : gen_bank
      // payload always follows the rotation, req only on grant
      assign bank_req_o[b].req  = rot_req[b].req & lane_gnt_o;
      assign bank_req_o[b].wen  = rot_req[b].wen;
      assign bank_req_o[b].be   = rot_req[b].be;
      assign bank_req_o[b].row  = rot_req[b].row;
      assign bank_req_o[b].data = rot_req[b].data;
    end
  endgenerate

  // all lanes share req and wen, lane 0 speaks for the request
  assign issue_rd = lane_gnt_o & lanes_i[0].req & lanes_i[0].wen;

  // remember where the last read landed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_offset_q <= '0;
    end else if (issue_rd) begin
      rd_offset_q <= offset_i;
    end
  end

  // rotate the bank outputs back into lane order
  generate
    for (genvar k = 0; k < tcdm_pkg::NB_LANES; k++) begin : gen_rdata
      assign lane_rdata_o[k] = bank_rdata_i[tcdm_pkg::bank_idx_t'(rd_offset_q + k)];
    end
  endgenerate

endmodule

/* hw/tcdm_bank.sv */
// **********************************************************
// scratchpad bank
// 32-bit word SRAM model with byte enables and a
// registered read port
// **********************************************************

`timescale 1ns/1ns

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::lane_req_t breq_i,
  output tcdm_pkg::word_t     rdata_o
);

  localparam int unsigned NB_ROWS = 2 ** tcdm_pkg::ROW_AW;

  tcdm_pkg::word_t mem_q [NB_ROWS];
  tcdm_pkg::word_t rdata_q;
  logic            wr_en;
  logic            rd_en;

  // wen high is a read
  assign wr_en = breq_i.req & ~breq_i.wen;
  assign rd_en = breq_i.req & breq_i.wen;

  // byte lane writes
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (breq_i.be[i]) begin
          mem_q[breq_i.row][i*8 +: 8] <= breq_i.data[i*8 +: 8];
        end
      end
    end
  end

  // read data shows up the cycle after the request
  // and holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[breq_i.row];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* hw/tcdm_wide_top.sv */
// **********************************************************
// wide port scratchpad top
// request FIFO, shallow router, lane reorder and eight
// word-interleaved banks
// **********************************************************

`timescale 1ns/1ns

module tcdm_wide_top #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  tcdm_pkg::wide_req_t  wreq_i,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output tcdm_pkg::wide_data_t r_data_o,
  input  tcdm_pkg::bank_mask_t bank_busy_i
);

  // FIFO head towards the router
  logic                                         hreq;
  tcdm_pkg::wide_req_t                          head;
  logic                                         pop;
  // lane side
  tcdm_pkg::lane_req_t [tcdm_pkg::NB_LANES-1:0] lanes;
  tcdm_pkg::bank_idx_t                          offset;
  logic                                         lane_gnt;
  tcdm_pkg::word_t [tcdm_pkg::NB_LANES-1:0]     lane_rdata;
  // bank side
  tcdm_pkg::lane_req_t [tcdm_pkg::NB_BANKS-1:0] bank_req;
  tcdm_pkg::word_t [tcdm_pkg::NB_BANKS-1:0]     bank_rdata;

  wide_req_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_fifo (
    .clk_i   ( clk_i  ), .rst_ni  ( rst_ni ),
    .req_i   ( req_i  ), .wreq_i  ( wreq_i ), .gnt_o ( gnt_o ),
    .pop_i   ( pop    ), .valid_o ( hreq   ), .head_o ( head )
  );

  shallow_router u_router (
    .clk_i        ( clk_i      ), .rst_ni       ( rst_ni     ),
    .valid_i      ( hreq       ), .head_i       ( head       ), .pop_o ( pop ),
    .lanes_o      ( lanes      ), .offset_o     ( offset     ),
    .lane_gnt_i   ( lane_gnt   ), .lane_rdata_i ( lane_rdata ),
    .r_valid_o    ( r_valid_o  ), .r_data_o     ( r_data_o   )
  );

  lane_reorder u_reorder (
    .clk_i        ( clk_i       ), .rst_ni       ( rst_ni      ),
    .offset_i     ( offset      ), .lanes_i      ( lanes       ),
    .bank_busy_i  ( bank_busy_i ), .lane_gnt_o   ( lane_gnt    ),
    .lane_rdata_o ( lane_rdata  ), .bank_req_o   ( bank_req    ),
    .bank_rdata_i ( bank_rdata  )
  );

  // one bank per word slot of the interleave
  for (genvar b = 0; b < tcdm_pkg::NB_BANKS; b++) begin : gen_bank
    tcdm_bank u_bank (
      .clk_i   ( clk_i         ), .rst_ni  ( rst_ni        ),
      .breq_i  ( bank_req[b]   ), .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

/* tests/tb_tcdm_wide.sv */
// **********************************************************
// wide port scratchpad testbench
// table driven and random requests checked against a flat
// word model of the scratchpad
// **********************************************************

`timescale 1ns/1ns

module tb_tcdm_wide;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned SETTLE       = 10;
  localparam int unsigned RESET_CYCLES = 8;
  localparam int unsigned MEM_WORDS    = tcdm_pkg::NB_BANKS * (2 ** tcdm_pkg::ROW_AW);
  localparam int unsigned IDX_W        = $clog2(MEM_WORDS);
  localparam int unsigned FILL_OPS     = MEM_WORDS / tcdm_pkg::NB_LANES;
  localparam int unsigned TABLE_LEN    = 26;
  localparam int unsigned RAND_OPS     = 200;
  localparam int unsigned BUSY_HOLD    = 4;
  localparam int unsigned WD_CYCLES    = (FILL_OPS + TABLE_LEN + RAND_OPS) * 20 + RESET_CYCLES;
  localparam logic [31:0] SEED         = 32'h390e_cacd;

  // table ops, hold and drain keep the cycle count in the data column
  localparam logic [1:0] OP_WR    = 2'd0;
  localparam logic [1:0] OP_RD    = 2'd1;
  localparam logic [1:0] OP_HOLD  = 2'd2;
  localparam logic [1:0] OP_DRAIN = 2'd3;

  typedef struct packed {
    logic [1:0]           op;
    tcdm_pkg::wide_addr_t addr;
    tcdm_pkg::wide_be_t   be;
    tcdm_pkg::wide_data_t data;
    tcdm_pkg::bank_mask_t busy;
  } stim_t;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  tcdm_pkg::wide_req_t  wreq_i;
  logic                 gnt_o;
  logic                 r_valid_o;
  tcdm_pkg::wide_data_t r_data_o;
  tcdm_pkg::bank_mask_t bank_busy_i;

  stim_t                stim_tbl [TABLE_LEN];
  tcdm_pkg::word_t      model_q [MEM_WORDS];
  tcdm_pkg::wide_data_t exp_q [$];
  logic [31:0]          lfsr_q;
  logic                 gnt_low_seen;
  int                   n_rows;
  int                   n_checks;
  int                   n_errors;
  int                   n_reads;
  int                   n_rvalid;

  tcdm_wide_top #(
    .FIFO_DEPTH ( 2 )
  ) u_tcdm_wide_top (
    .clk_i       ( clk_i       ), .rst_ni    ( rst_ni    ),
    .req_i       ( req_i       ), .wreq_i    ( wreq_i    ), .gnt_o ( gnt_o ),
    .r_valid_o   ( r_valid_o   ), .r_data_o  ( r_data_o  ),
    .bank_busy_i ( bank_busy_i )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_val(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // preload pattern, every word index gives a different value
  function automatic tcdm_pkg::word_t fill_word(input int unsigned w);
    return (w * 32'h9e37_79b9) ^ (w << 20) ^ 32'h5a5a_0f0f;
  endfunction

  // lane k of a request is word addr/4 + k, modulo the scratchpad size
  task automatic update_model(input logic [1:0] op, input tcdm_pkg::wide_addr_t addr,
                              input tcdm_pkg::wide_be_t be, input tcdm_pkg::wide_data_t data);
    int unsigned          w;
    logic [IDX_W-1:0]     idx;
    tcdm_pkg::wide_data_t exp;
    w   = addr >> 2;
    exp = '0;
    for (int unsigned k = 0; k < tcdm_pkg::NB_LANES; k++) begin
      idx = IDX_W'(w + k);
      if (op == OP_RD) begin
        exp[k*32 +: 32] = model_q[idx];
      end else begin
        for (int unsigned j = 0; j < 4; j++) begin
          if (be[k*4+j]) begin
            model_q[idx][j*8 +: 8] = data[k*32+j*8 +: 8];
          end
        end
      end
    end
    if (op == OP_RD) begin
      exp_q.push_back(exp);
      n_reads++;
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic drive_req(input logic [1:0] op, input tcdm_pkg::wide_addr_t addr,
                           input tcdm_pkg::wide_be_t be, input tcdm_pkg::wide_data_t data,
                           input tcdm_pkg::bank_mask_t busy);
    int unsigned waited;
    req_i       = 1'b1;
    wreq_i      = '{wen: (op == OP_RD), be: be, addr: addr, data: data};
    bank_busy_i = busy;
    waited      = 0;
    // gnt_o sampled mid cycle, clear of both edges
    #SETTLE;
    while (!gnt_o) begin
      gnt_low_seen = 1'b1;
      @(negedge clk_i);
      waited++;
      // release the banks so a blocked head can drain
      if (waited == BUSY_HOLD) begin
        bank_busy_i = '0;
      end
      #SETTLE;
    end
    update_model(op, addr, be, data);
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  // busy stays on, the pending read must not come back
  task automatic hold_busy(input tcdm_pkg::bank_mask_t busy, input int cycles);
    bank_busy_i = busy;
    repeat (cycles) @(negedge clk_i);
    #SETTLE;
    check_val("read held by busy bank", 128'(exp_q.size() != 0), 128'd1);
    @(negedge clk_i);
  endtask

  task automatic drain_reads(input tcdm_pkg::bank_mask_t busy, input int cycles);
    int waited;
    bank_busy_i = busy;
    waited      = 0;
    #SETTLE;
    while (exp_q.size() != 0 && waited < cycles) begin
      @(negedge clk_i);
      #SETTLE;
      waited++;
    end
    check_val("reads left after drain", 128'(exp_q.size()), 128'd0);
    @(negedge clk_i);
  endtask

  task automatic add_row(input logic [1:0] op, input tcdm_pkg::wide_addr_t addr,
                         input tcdm_pkg::wide_be_t be, input tcdm_pkg::wide_data_t data,
                         input tcdm_pkg::bank_mask_t busy);
    stim_tbl[n_rows] = '{op, addr, be, data, busy};
    n_rows++;
  endtask

  task automatic load_table();
    n_rows = 0;
    // offset 0, then offsets 5 6 7 that wrap onto the next row
    add_row(OP_WR, 'h000, 16'hffff, 128'h0303_0303_0202_0202_0101_0101_0000_0000, 8'h00);
    add_row(OP_RD, 'h000, 16'hffff, 128'h0, 8'h00);
    add_row(OP_WR, 'h0b4, 16'hffff, 128'h1111_2222_3333_4444_5555_6666_7777_8888, 8'h00);
    add_row(OP_WR, 'h0d8, 16'hffff, 128'ha0a1_a2a3_b0b1_b2b3_c0c1_c2c3_d0d1_d2d3, 8'h00);
    add_row(OP_WR, 'h0fc, 16'hffff, 128'hfeed_0003_feed_0002_feed_0001_feed_0000, 8'h00);
    add_row(OP_RD, 'h0b4, 16'hffff, 128'h0, 8'h00);
    add_row(OP_RD, 'h0d8, 16'hffff, 128'h0, 8'h00);
    add_row(OP_RD, 'h0fc, 16'hffff, 128'h0, 8'h00);
    // neighbours on both sides of the wrap
    add_row(OP_RD, 'h0f0, 16'hffff, 128'h0, 8'h00);
    add_row(OP_RD, 'h100, 16'hffff, 128'h0, 8'h00);
    // last row wraps to row 0
    add_row(OP_RD, 'h7f4, 16'hffff, 128'h0, 8'h00);
    // partial byte enables
    add_row(OP_WR, 'h144, 16'h8421, 128'hdead_beef_cafe_f00d_1234_5678_9abc_def0, 8'h00);
    add_row(OP_RD, 'h144, 16'hffff, 128'h0, 8'h00);
    add_row(OP_WR, 'h1bc, 16'h0ff0, 128'h0bad_c0de_5555_aaaa_6666_9999_7777_8888, 8'h00);
    add_row(OP_RD, 'h1bc, 16'hffff, 128'h0, 8'h00);
    // bank 4 busy but only banks 0..3 targeted
    add_row(OP_RD, 'h200, 16'hffff, 128'h0, 8'h10);
    add_row(OP_DRAIN, 'h0, 16'h0, 128'd8, 8'h10);
    // bank 5 busy and targeted
    add_row(OP_RD, 'h20c, 16'hffff, 128'h0, 8'h20);
    add_row(OP_HOLD, 'h0, 16'h0, 128'd6, 8'h20);
    add_row(OP_DRAIN, 'h0, 16'h0, 128'd8, 8'h00);
    // head blocked on bank 2, FIFO fills and gnt_o drops
    add_row(OP_WR, 'h220, 16'hffff, 128'h6000_0003_6000_0002_6000_0001_6000_0000, 8'h04);
    add_row(OP_WR, 'h230, 16'hffff, 128'h7000_0003_7000_0002_7000_0001_7000_0000, 8'h04);
    add_row(OP_WR, 'h240, 16'hffff, 128'h8000_0003_8000_0002_8000_0001_8000_0000, 8'h04);
    add_row(OP_RD, 'h220, 16'hffff, 128'h0, 8'h00);
    add_row(OP_RD, 'h230, 16'hffff, 128'h0, 8'h00);
    add_row(OP_DRAIN, 'h0, 16'h0, 128'd10, 8'h00);
  endtask

  // read responses come back in issue order
  always @(negedge clk_i) begin
    if (rst_ni && r_valid_o) begin
      n_rvalid++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("read response at %0t with no read outstanding", $time);
      end else begin
        check_val("read data", r_data_o, exp_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0]          r;
    logic [1:0]           op;
    tcdm_pkg::wide_addr_t addr;
    tcdm_pkg::wide_be_t   be;
    tcdm_pkg::wide_data_t data;
    tcdm_pkg::bank_mask_t busy;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    wreq_i       = '0;
    bank_busy_i  = '0;
    lfsr_q       = SEED;
    gnt_low_seen = 1'b0;
    n_checks     = 0;
    n_errors     = 0;
    n_reads      = 0;
    n_rvalid     = 0;
    load_table();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    #SETTLE;
    check_val("gnt_o after reset", 128'(gnt_o), 128'd1);
    check_val("r_valid_o after reset", 128'(r_valid_o), 128'd0);
    @(negedge clk_i);
    // known contents everywhere before any read
    for (int unsigned i = 0; i < FILL_OPS; i++) begin
      for (int unsigned k = 0; k < tcdm_pkg::NB_LANES; k++) begin
        data[k*32 +: 32] = fill_word(i * tcdm_pkg::NB_LANES + k);
      end
      drive_req(OP_WR, tcdm_pkg::wide_addr_t'(i * 16), '1, data, '0);
    end
    gnt_low_seen = 1'b0;
    for (int i = 0; i < TABLE_LEN; i++) begin
      case (stim_tbl[i].op)
        OP_HOLD:  hold_busy(stim_tbl[i].busy, int'(stim_tbl[i].data[7:0]));
        OP_DRAIN: drain_reads(stim_tbl[i].busy, int'(stim_tbl[i].data[7:0]));
        default:  drive_req(stim_tbl[i].op, stim_tbl[i].addr, stim_tbl[i].be,
                            stim_tbl[i].data, stim_tbl[i].busy);
      endcase
    end
    check_val("gnt_o dropped with full FIFO", 128'(gnt_low_seen), 128'd1);
    // random mix, busy on about a quarter of the requests
    for (int i = 0; i < RAND_OPS; i++) begin
      take_bits(1, r);
      op = r[0] ? OP_RD : OP_WR;
      take_bits(9, r);
      addr = {21'd0, r[8:0], 2'b00};
      take_bits(2, r);
      addr[1:0] = r[1:0];
      take_bits(16, r);
      be = r[15:0];
      for (int k = 0; k < tcdm_pkg::NB_LANES; k++) begin
        take_bits(32, r);
        data[k*32 +: 32] = r;
      end
      take_bits(2, r);
      busy = '0;
      if (r[1:0] == 2'b00) begin
        take_bits(8, r);
        busy = r[7:0];
      end
      drive_req(op, addr, be, data, busy);
    end
    drain_reads('0, 40);
    check_val("response count", 128'(n_rvalid), 128'(n_reads));
    $display("checks %0d errors %0d reads %0d responses %0d",
             n_checks, n_errors, n_reads, n_rvalid);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // sized from the number of requests with a wide margin per request
  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles, the run did not finish", WD_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* list.f */
hw/tcdm_pkg.sv
hw/wide_req_fifo.sv
hw/shallow_router.sv
hw/lane_reorder.sv
hw/tcdm_bank.sv
hw/tcdm_wide_top.sv
tests/tb_tcdm_wide.sv

/* Makefile */
# Verilator build and run of the wide port scratchpad testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_wide
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail is decided from the log
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^Result: PASSED$$' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
